// ==== filelist.f ====
design/usbLitePkg.sv
design/usbLiteFifo.sv
design/usbLiteRegs.sv
design/usbLiteTxWire.sv
design/usbLiteRxWire.sv
design/usbLiteAvalonWrap.sv
test/usbLiteBus_assert.sv
test/usbLiteChecker.sv
test/usbLiteTb.sv

// ==== Bender.yml ====
package:
  name: usb_lite

sources:
  - files:
      - design/usbLitePkg.sv
      - design/usbLiteFifo.sv
      - design/usbLiteRegs.sv
      - design/usbLiteTxWire.sv
      - design/usbLiteRxWire.sv
      - design/usbLiteAvalonWrap.sv
  - target: test
    files:
      - test/usbLiteBus_assert.sv
      - test/usbLiteChecker.sv
      - test/usbLiteTb.sv

// ==== test/usbLiteTb.sv ====
`timescale 1ns/1ns

module usbLiteTb;
  import usbLitePkg::*;

  localparam int LOOP_BYTES  = 6;
  localparam int OVF_BYTES   = RX_FIFO_DEPTH + 3;
  localparam int TOTAL_BYTES = 2 * LOOP_BYTES + OVF_BYTES;
  // Low speed bit time bounds every byte; the margin covers bus traffic.
  localparam int CYCLE_LIMIT = TOTAL_BYTES * DATA_W * LS_DIV + 4000;

  logic              clk;
  logic              arstN;
  logic [ADDR_W-1:0] address;
  logic [DATA_W-1:0] writeData;
  logic [DATA_W-1:0] readData;
  logic              write;
  logic              read;
  logic              chipSelect;
  logic              waitRequest;
  logic              irq;
  logic              vpi;
  logic              vmi;
  logic              vpo;
  logic              vmo;
  logic              inTick;
  logic              outTick;
  logic              outEnN;
  logic              fullSpeed;
  logic [15:0]       lfsr;
  int                cycles;
  int                tbErrors;
  int                chkErrors;
  logic [DATA_W-1:0] rdData;
  logic [DATA_W-1:0] txByte;

  usbLiteAvalonWrap dut_i (
    .clk_i(clk), .arstN_i(arstN), .address_i(address), .writeData_i(writeData),
    .readData_o(readData), .write_i(write), .read_i(read), .chipSelect_i(chipSelect),
    .waitRequest_o(waitRequest), .irq_o(irq), .USBWireVPI_i(vpi), .USBWireVMI_i(vmi),
    .USBWireVPO_o(vpo), .USBWireVMO_o(vmo), .USBWireDataInTick_o(inTick),
    .USBWireDataOutTick_o(outTick), .USBWireOutEn_n_o(outEnN), .USBFullSpeed_o(fullSpeed)
  );

  usbLiteChecker chk_i (
    .clk_i(clk), .arstN_i(arstN), .address_i(address), .writeData_i(writeData),
    .readData_i(readData), .write_i(write), .read_i(read), .chipSelect_i(chipSelect),
    .waitRequest_i(waitRequest), .irq_i(irq), .dataInTick_i(inTick),
    .dataOutTick_i(outTick), .errors_o(chkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Line loopback, SE0 while the transmitter is off.
  always @(negedge clk) begin
    vpi = outEnN ? 1'b0 : vpo;
    vmi = outEnN ? 1'b0 : vmo;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  // ####################################################################
  // Helpers.
  // ####################################################################
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic randBits(input int n, output logic [DATA_W-1:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsrNext(lfsr);
      value = {value[DATA_W-2:0], lfsr[0]};
    end
  endtask

  task automatic checkValue(input string name, input logic [DATA_W-1:0] expVal,
                            input logic [DATA_W-1:0] actVal);
    if (actVal !== expVal) begin
      $display("FAIL at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, expVal, actVal);
      tbErrors++;
    end
  endtask

  task automatic busAccess(input logic isWrite, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wData, output logic [DATA_W-1:0] rData);
    @(negedge clk);
    chipSelect = 1'b1;
    write      = isWrite;
    read       = !isWrite;
    address    = addr;
    writeData  = wData;
    @(negedge clk);
    while (waitRequest) @(negedge clk);
    rData = readData;
    @(negedge clk);
    chipSelect = 1'b0;
    write      = 1'b0;
    read       = 1'b0;
  endtask

  task automatic busWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wData);
    logic [DATA_W-1:0] unused;
    busAccess(1'b1, addr, wData, unused);
  endtask

  task automatic busRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rData);
    busAccess(1'b0, addr, '0, rData);
  endtask

  task automatic waitRxByte();
    logic [DATA_W-1:0] stat;
    stat = '1;
    while (stat[FSTAT_RXEMPTY]) busRead(ADDR_FIFOSTAT, stat);
  endtask

  task automatic waitLineIdle();
    logic [DATA_W-1:0] stat;
    stat = '0;
    while (!stat[FSTAT_TXEMPTY]) busRead(ADDR_FIFOSTAT, stat);
    while (!outEnN) @(negedge clk);
    repeat (4) @(negedge clk);  // Last push reaches the RX FIFO.
  endtask

  // ####################################################################
  // Test sequence.
  // ####################################################################
  initial begin
    lfsr       = 16'd63620;
    tbErrors   = 0;
    arstN      = 1'b0;
    chipSelect = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    address    = '0;
    writeData  = '0;
    vpi        = 1'b0;
    vmi        = 1'b0;
    repeat (16) @(negedge clk);
    arstN = 1'b1;

    checkValue("irq_o", '0, DATA_W'(irq));
    checkValue("USBWireOutEn_n_o", 8'd1, DATA_W'(outEnN));
    busRead(ADDR_CONTROL, rdData);
    busRead(ADDR_STATUS, rdData);
    busRead(ADDR_INTMASK, rdData);
    busRead(ADDR_FIFOSTAT, rdData);
    checkValue("FIFOSTAT", DATA_W'((1 << FSTAT_TXEMPTY) | (1 << FSTAT_RXEMPTY)), rdData);

    for (int i = 0; i < 8; i++) begin
      randBits(DATA_W, txByte);
      busWrite(ADDR_CONTROL, txByte);
      busRead(ADDR_CONTROL, rdData);
      randBits(DATA_W, txByte);
      busWrite(ADDR_INTMASK, txByte);
      busRead(ADDR_INTMASK, rdData);
    end
    busWrite(ADDR_INTMASK, '0);

    // Low speed first, then full speed.
    for (int speed = 0; speed < 2; speed++) begin
      busWrite(ADDR_CONTROL,
               DATA_W'((1 << CTRL_TXEN) | (1 << CTRL_RXEN) | (speed << CTRL_FULLSPEED)));
      checkValue("USBFullSpeed_o", DATA_W'(speed), DATA_W'(fullSpeed));
      for (int n = 0; n < LOOP_BYTES; n++) begin
        randBits(DATA_W, txByte);
        busWrite(ADDR_TXDATA, txByte);
      end
      for (int n = 0; n < LOOP_BYTES; n++) begin
        waitRxByte();
        busRead(ADDR_RXDATA, rdData);
      end
    end

    // Overflow, RX FIFO left unread until the line is idle.
    for (int n = 0; n < OVF_BYTES; n++) begin
      randBits(DATA_W, txByte);
      busWrite(ADDR_TXDATA, txByte);
    end
    waitLineIdle();
    busRead(ADDR_STATUS, rdData);
    for (int n = 0; n < RX_FIFO_DEPTH; n++) begin
      busRead(ADDR_RXDATA, rdData);
    end
    busRead(ADDR_FIFOSTAT, rdData);
    checkValue("FIFOSTAT RXEMPTY", 8'd1, DATA_W'(rdData[FSTAT_RXEMPTY]));

    for (int i = 0; i < 6; i++) begin
      randBits(INT_W, txByte);
      busWrite(ADDR_INTMASK, txByte);
      busRead(ADDR_STATUS, rdData);
      randBits(INT_W, txByte);
      busWrite(ADDR_STATUS, txByte);
      busRead(ADDR_STATUS, rdData);
    end

    $display("Errors: checker %0d, testbench %0d, assertions %0d",
             chkErrors, tbErrors, dut_i.busAssert_i.failCount);
    if (chkErrors + tbErrors + dut_i.busAssert_i.failCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== test/usbLiteChecker.sv ====
`timescale 1ns/1ns

module usbLiteChecker (
  input  logic                          clk_i,
  input  logic                          arstN_i,
  input  logic [usbLitePkg::ADDR_W-1:0] address_i,
  input  logic [usbLitePkg::DATA_W-1:0] writeData_i,
  input  logic [usbLitePkg::DATA_W-1:0] readData_i,
  input  logic                          write_i,
  input  logic                          read_i,
  input  logic                          chipSelect_i,
  input  logic                          waitRequest_i,
  input  logic                          irq_i,
  input  logic                          dataInTick_i,
  input  logic                          dataOutTick_i,
  output int                            errors_o
);
  import usbLitePkg::*;

  logic [CTRL_W-1:0] control;
  logic [INT_W-1:0]  status;
  logic [INT_W-1:0]  intMask;
  logic [DATA_W-1:0] rxQueue [$];  // Bytes written to TXDATA that the RX FIFO will hold.
  logic              ack;
  logic              ctrlWr;
  int                txBytes;   // Bytes accepted for transmission.
  int                outTicks;
  int                tickGap;   // Cycles since the last receive sample.
  logic              gapValid;

  assign ack    = chipSelect_i && (read_i || write_i) && !waitRequest_i;
  assign ctrlWr = ack && write_i && (address_i == ADDR_CONTROL);

  initial errors_o = 0;

  task automatic compareValue(input string name, input logic [DATA_W-1:0] expVal,
                              input logic [DATA_W-1:0] actVal);
    if (actVal !== expVal) begin
      $display("FAIL at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, expVal, actVal);
      errors_o++;
    end
  endtask

  task automatic compareCount(input string name, input int expVal, input int actVal);
    if (actVal != expVal) begin
      $display("FAIL at %0t ns: %s expected %0d, got %0d", $time, name, expVal, actVal);
      errors_o++;
    end
  endtask

  task automatic compareIrq();
    compareValue("irq_o", DATA_W'(|(status & intMask)), DATA_W'(irq_i));
  endtask

  // ####################################################################
  // Model update and read compare, once per acknowledged access.
  // ####################################################################
  always @(negedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      control = '0;
      status  = '0;
      intMask = '0;
      txBytes = 0;
      rxQueue.delete();
    end else if (ack && read_i) begin
      case (address_i)
        ADDR_CONTROL: compareValue("readData_o CONTROL", DATA_W'(control), readData_i);
        ADDR_STATUS: begin
          compareValue("readData_o STATUS", DATA_W'(status), readData_i);
          compareIrq();
        end
        ADDR_INTMASK: begin
          compareValue("readData_o INTMASK", DATA_W'(intMask), readData_i);
          compareIrq();
        end
        ADDR_RXDATA: begin
          if (rxQueue.size() == 0) begin
            compareValue("readData_o RXDATA", '0, readData_i);  // Empty FIFO reads 0.
          end else begin
            compareValue("readData_o RXDATA", rxQueue.pop_front(), readData_i);
          end
        end
        ADDR_FIFOSTAT: begin
          compareValue("FIFOSTAT TXFULL", '0, DATA_W'(readData_i[FSTAT_TXFULL]));
          if (rxQueue.size() == 0) begin
            compareValue("FIFOSTAT RXEMPTY", 8'd1, DATA_W'(readData_i[FSTAT_RXEMPTY]));
          end
        end
        default: ;
      endcase
    end else if (ack && write_i) begin
      case (address_i)
        ADDR_CONTROL: control = writeData_i[CTRL_W-1:0];
        ADDR_INTMASK: intMask = writeData_i[INT_W-1:0];
        ADDR_STATUS:  status  = status & ~writeData_i[INT_W-1:0];
        ADDR_TXDATA: begin
          // Status reads happen only once the line is idle again.
          if (control[CTRL_TXEN]) begin
            txBytes++;
            status[INT_TXDONE] = 1'b1;
            if (control[CTRL_RXEN]) begin
              status[INT_RXBYTE] = 1'b1;
              if (rxQueue.size() < RX_FIFO_DEPTH) begin
                rxQueue.push_back(writeData_i);
              end else begin
                status[INT_RXOVF] = 1'b1;
              end
            end
          end
        end
        default: ;
      endcase
    end
  end

  // ####################################################################
  // Line ticks against the divisor and the bytes sent.
  // ####################################################################
  always @(negedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      outTicks = 0;
      tickGap  = 0;
      gapValid = 1'b0;
    end else begin
      tickGap++;
      if (dataOutTick_i) begin
        outTicks++;
      end
      if (ctrlWr) begin
        gapValid = 1'b0;  // Rate and enables may change here.
      end else if (dataInTick_i) begin
        if (gapValid) begin
          compareCount("USBWireDataInTick_o spacing",
                       control[CTRL_FULLSPEED] ? FS_DIV : LS_DIV, tickGap);
        end
        tickGap  = 0;
        gapValid = 1'b1;
      end
      if (ack && read_i && address_i == ADDR_STATUS) begin
        // Each byte sent gives eight output ticks.
        compareCount("USBWireDataOutTick_o count", DATA_W * txBytes, outTicks);
      end
    end
  end

endmodule

// ==== test/usbLiteBus_assert.sv ====
`timescale 1ns/1ns

module usbLiteBus_assert (
  input logic                         clk_i,
  input logic                         arstN_i,
  input logic                         chipSelect_i,
  input logic                         read_i,
  input logic                         write_i,
  input logic                         waitRequest_i,
  input logic                         outEnN_i,
  input logic                         vpo_i,
  input logic                         vmo_i,
  input logic                         irq_i,
  input logic [usbLitePkg::INT_W-1:0] intMask_i
);

  int failCount;

  initial failCount = 0;

  // Acknowledge lasts a single cycle.
  assert property (@(posedge clk_i) disable iff (!arstN_i)
    (chipSelect_i && (read_i || write_i) && !waitRequest_i) |=> waitRequest_i)
    else begin
      $error("waitRequest_o was low on two consecutive cycles of one access");
      failCount++;
    end

  assert property (@(posedge clk_i) disable iff (!arstN_i)
    outEnN_i |-> (!vpo_i && !vmo_i))  // Undriven line sits at SE0.
    else begin
      $error("line pair not at SE0 while the output enable is off");
      failCount++;
    end

  assert property (@(posedge clk_i) disable iff (!arstN_i)
    (intMask_i == '0) |-> !irq_i)
    else begin
      $error("irq_o high with every interrupt masked");
      failCount++;
    end

endmodule

bind usbLiteAvalonWrap usbLiteBus_assert busAssert_i (
  .clk_i,
  .arstN_i,
  .chipSelect_i,
  .read_i,
  .write_i,
  .waitRequest_i(waitRequest_o),
  .outEnN_i(USBWireOutEn_n_o),
  .vpo_i(USBWireVPO_o),
  .vmo_i(USBWireVMO_o),
  .irq_i(irq_o),
  .intMask_i(regs_i.intMask)
);

// ==== design/usbLiteAvalonWrap.sv ====
`timescale 1ns/1ns

module usbLiteAvalonWrap (
  input  logic                          clk_i,
  input  logic                          arstN_i,
  input  logic [usbLitePkg::ADDR_W-1:0] address_i,
  input  logic [usbLitePkg::DATA_W-1:0] writeData_i,
  output logic [usbLitePkg::DATA_W-1:0] readData_o,
  input  logic                          write_i,
  input  logic                          read_i,
  input  logic                          chipSelect_i,
  output logic                          waitRequest_o,
  output logic                          irq_o,
  input  logic                          USBWireVPI_i,
  input  logic                          USBWireVMI_i,
  output logic                          USBWireVPO_o,
  output logic                          USBWireVMO_o,
  output logic                          USBWireDataInTick_o,
  output logic                          USBWireDataOutTick_o,
  output logic                          USBWireOutEn_n_o,
  output logic                          USBFullSpeed_o
);
  import usbLitePkg::*;

  logic              txPush;
  logic [DATA_W-1:0] txData;
  logic              txPop;
  logic [DATA_W-1:0] txHead;
  logic              txFull;
  logic              txEmpty;
  logic              rxPush;
  logic [DATA_W-1:0] rxByte;
  logic              rxPop;
  logic [DATA_W-1:0] rxHead;
  logic              rxFull;
  logic              rxEmpty;
  logic              txDone;
  logic              txEnable;
  logic              rxEnable;
  logic              bitTick;
  logic              outEn;

  assign USBWireOutEn_n_o = !outEn;  // Pad enable is active low.

  usbLiteRegs regs_i (
    .clk_i, .arstN_i, .address_i, .writeData_i, .readData_o,
    .write_i, .read_i, .chipSelect_i, .waitRequest_o,
    .txPush_o(txPush), .txData_o(txData), .txFull_i(txFull), .txEmpty_i(txEmpty),
    .rxPop_o(rxPop), .rxData_i(rxHead), .rxEmpty_i(rxEmpty),
    .rxPush_i(rxPush), .rxFull_i(rxFull), .txDone_i(txDone),
    .txEnable_o(txEnable), .rxEnable_o(rxEnable), .fullSpeed_o(USBFullSpeed_o),
    .irq_o
  );

  usbLiteFifo #(.DEPTH(TX_FIFO_DEPTH)) txFifo_i (
    .clk_i, .arstN_i, .push_i(txPush), .data_i(txData), .pop_i(txPop),
    .data_o(txHead), .full_o(txFull), .empty_o(txEmpty)
  );

  usbLiteFifo #(.DEPTH(RX_FIFO_DEPTH)) rxFifo_i (
    .clk_i, .arstN_i, .push_i(rxPush), .data_i(rxByte), .pop_i(rxPop),
    .data_o(rxHead), .full_o(rxFull), .empty_o(rxEmpty)
  );

  usbLiteTxWire txWire_i (
    .clk_i, .arstN_i, .txEnable_i(txEnable), .fullSpeed_i(USBFullSpeed_o),
    .fifoData_i(txHead), .fifoEmpty_i(txEmpty), .fifoPop_o(txPop),
    .bitTick_o(bitTick), .lineVp_o(USBWireVPO_o), .lineVm_o(USBWireVMO_o),
    .outEn_o(outEn), .dataOutTick_o(USBWireDataOutTick_o), .txDone_o(txDone)
  );

  // Receiver shares the transmit bit tick.
  usbLiteRxWire rxWire_i (
    .clk_i, .arstN_i, .rxEnable_i(rxEnable), .bitTick_i(bitTick),
    .lineVp_i(USBWireVPI_i), .lineVm_i(USBWireVMI_i),
    .rxPush_o(rxPush), .rxData_o(rxByte), .dataInTick_o(USBWireDataInTick_o)
  );

endmodule

// ==== design/usbLiteRxWire.sv ====
`timescale 1ns/1ns

module usbLiteRxWire (
  input  logic                          clk_i,
  input  logic                          arstN_i,
  input  logic                          rxEnable_i,
  input  logic                          bitTick_i,
  input  logic                          lineVp_i,
  input  logic                          lineVm_i,
  output logic                          rxPush_o,
  output logic [usbLitePkg::DATA_W-1:0] rxData_o,
  output logic                          dataInTick_o
);
  import usbLitePkg::*;

  logic                 sample;
  logic                 se0;
  logic [BIT_CNT_W-1:0] bitCnt;
  logic [DATA_W-1:0]    shiftReg;

  assign sample       = bitTick_i && rxEnable_i;
  assign se0          = !lineVp_i && !lineVm_i;
  assign dataInTick_o = sample;
  assign rxData_o     = shiftReg;  // Complete when rxPush_o is high.

  // ####################################################################
  // Bit counter, resynchronized by SE0.
  // ####################################################################
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      bitCnt   <= '0;
      rxPush_o <= 1'b0;
    end else begin
      rxPush_o <= 1'b0;
      if (!rxEnable_i) begin
        bitCnt <= '0;
      end else if (sample) begin
        if (se0) begin
          bitCnt <= '0;
        end else begin
          bitCnt   <= bitCnt + 1'b1;
          rxPush_o <= (bitCnt == '1);  // Eighth bit.
        end
      end
    end
  end

  // LSB first, so new bits enter at the top.
  always_ff @(posedge clk_i) begin
    if (sample && !se0) begin
      shiftReg <= {lineVp_i, shiftReg[DATA_W-1:1]};
    end
  end

endmodule

// ==== design/usbLiteTxWire.sv ====
`timescale 1ns/1ns

module usbLiteTxWire (
  input  logic                          clk_i,
  input  logic                          arstN_i,
  input  logic                          txEnable_i,
  input  logic                          fullSpeed_i,
  input  logic [usbLitePkg::DATA_W-1:0] fifoData_i,
  input  logic                          fifoEmpty_i,
  output logic                          fifoPop_o,
  output logic                          bitTick_o,
  output logic                          lineVp_o,
  output logic                          lineVm_o,
  output logic                          outEn_o,
  output logic                          dataOutTick_o,
  output logic                          txDone_o
);
  import usbLitePkg::*;

  logic [DIV_W-1:0]     divCnt;
  logic [DIV_W-1:0]     divLast;
  logic                 bitTick;
  logic                 busy;
  logic [BIT_CNT_W-1:0] bitCnt;
  logic [DATA_W-1:0]    shiftReg;
  logic                 loadByte;

  assign divLast = fullSpeed_i ? DIV_W'(FS_DIV - 1) : DIV_W'(LS_DIV - 1);

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      divCnt  <= '0;
      bitTick <= 1'b0;
    end else if (!txEnable_i) begin
      divCnt  <= '0;
      bitTick <= 1'b0;
    end else if (divCnt >= divLast) begin  // Also catches a speed change.
      divCnt  <= '0;
      bitTick <= 1'b1;
    end else begin
      divCnt  <= divCnt + 1'b1;
      bitTick <= 1'b0;
    end
  end

  // Bit count wraps to 0 once bit 7 is on the line.
  assign loadByte      = bitTick && (!busy || bitCnt == '0) && !fifoEmpty_i;
  assign fifoPop_o     = loadByte;
  assign bitTick_o     = bitTick;
  assign outEn_o       = busy;
  assign dataOutTick_o = bitTick && busy;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      busy     <= 1'b0;
      bitCnt   <= '0;
      lineVp_o <= 1'b0;
      lineVm_o <= 1'b0;
      txDone_o <= 1'b0;
    end else begin
      txDone_o <= 1'b0;
      if (!txEnable_i) begin
        busy     <= 1'b0;
        bitCnt   <= '0;
        lineVp_o <= 1'b0;
        lineVm_o <= 1'b0;
      end else if (loadByte) begin
        busy     <= 1'b1;
        bitCnt   <= BIT_CNT_W'(1);
        lineVp_o <= fifoData_i[0];
        lineVm_o <= !fifoData_i[0];
      end else if (bitTick && busy) begin
        if (bitCnt == '0) begin
          busy     <= 1'b0;  // Queue drained, back to SE0.
          lineVp_o <= 1'b0;
          lineVm_o <= 1'b0;
          txDone_o <= 1'b1;
        end else begin
          bitCnt   <= bitCnt + 1'b1;
          lineVp_o <= shiftReg[0];
          lineVm_o <= !shiftReg[0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (loadByte) begin
      shiftReg <= fifoData_i >> 1;
    end else if (bitTick && busy) begin
      shiftReg <= shiftReg >> 1;
    end
  end

endmodule

// ==== design/usbLiteRegs.sv ====
`timescale 1ns/1ns

module usbLiteRegs (
  input  logic                          clk_i,
  input  logic                          arstN_i,
  input  logic [usbLitePkg::ADDR_W-1:0] address_i,
  input  logic [usbLitePkg::DATA_W-1:0] writeData_i,
  output logic [usbLitePkg::DATA_W-1:0] readData_o,
  input  logic                          write_i,
  input  logic                          read_i,
  input  logic                          chipSelect_i,
  output logic                          waitRequest_o,
  output logic                          txPush_o,
  output logic [usbLitePkg::DATA_W-1:0] txData_o,
  input  logic                          txFull_i,
  input  logic                          txEmpty_i,
  output logic                          rxPop_o,
  input  logic [usbLitePkg::DATA_W-1:0] rxData_i,
  input  logic                          rxEmpty_i,
  input  logic                          rxPush_i,
  input  logic                          rxFull_i,
  input  logic                          txDone_i,
  output logic                          txEnable_o,
  output logic                          rxEnable_o,
  output logic                          fullSpeed_o,
  output logic                          irq_o
);
  import usbLitePkg::*;

  logic               strobe;
  logic               ack;
  logic               wrAck;
  logic               rdAck;
  logic [CTRL_W-1:0]  control;
  logic [INT_W-1:0]   status;
  logic [INT_W-1:0]   statusNext;
  logic [INT_W-1:0]   intMask;
  logic [INT_W-1:0]   intMaskNext;
  logic [INT_W-1:0]   intSet;
  logic [INT_W-1:0]   intClr;
  logic [FSTAT_W-1:0] fifoStat;

  // ####################################################################
  // One wait state per access.
  // ####################################################################
  assign strobe        = chipSelect_i && (read_i || write_i);
  assign waitRequest_o = !ack;
  assign wrAck         = ack && chipSelect_i && write_i;
  assign rdAck         = ack && chipSelect_i && read_i;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      ack <= 1'b0;
    end else begin
      ack <= strobe && !ack;
    end
  end

  // FIFO side effects.
  assign txPush_o = wrAck && (address_i == ADDR_TXDATA) && !txFull_i;
  assign txData_o = writeData_i;
  assign rxPop_o  = rdAck && (address_i == ADDR_RXDATA) && !rxEmpty_i;

  assign txEnable_o  = control[CTRL_TXEN];
  assign rxEnable_o  = control[CTRL_RXEN];
  assign fullSpeed_o = control[CTRL_FULLSPEED];

  // ####################################################################
  // Interrupt status, mask and request.
  // ####################################################################
  always_comb begin
    intSet             = '0;
    intSet[INT_TXDONE] = txDone_i;
    intSet[INT_RXBYTE] = rxPush_i;
    intSet[INT_RXOVF]  = rxPush_i && rxFull_i;  // Byte dropped.
  end

  assign intClr      = (wrAck && address_i == ADDR_STATUS) ? writeData_i[INT_W-1:0] : '0;
  assign statusNext  = (status & ~intClr) | intSet;  // New events win over clear.
  assign intMaskNext = (wrAck && address_i == ADDR_INTMASK) ? writeData_i[INT_W-1:0]
                                                            : intMask;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      control <= '0;
      status  <= '0;
      intMask <= '0;
      irq_o   <= 1'b0;
    end else begin
      if (wrAck && address_i == ADDR_CONTROL) begin
        control <= writeData_i[CTRL_W-1:0];
      end
      status  <= statusNext;
      intMask <= intMaskNext;
      irq_o   <= |(statusNext & intMaskNext);
    end
  end

  // ####################################################################
  // Read decode.
  // ####################################################################
  always_comb begin
    fifoStat                = '0;
    fifoStat[FSTAT_TXFULL]  = txFull_i;
    fifoStat[FSTAT_TXEMPTY] = txEmpty_i;
    fifoStat[FSTAT_RXEMPTY] = rxEmpty_i;
  end

  always_comb begin
    case (address_i)
      ADDR_CONTROL:  readData_o = DATA_W'(control);
      ADDR_STATUS:   readData_o = DATA_W'(status);
      ADDR_INTMASK:  readData_o = DATA_W'(intMask);
      ADDR_RXDATA:   readData_o = rxEmpty_i ? '0 : rxData_i;
      ADDR_FIFOSTAT: readData_o = DATA_W'(fifoStat);
      default:       readData_o = '0;  // TXDATA is write only.
    endcase
  end

endmodule

// ==== design/usbLiteFifo.sv ====
`timescale 1ns/1ns

module usbLiteFifo #(
  parameter int DEPTH = 8
) (
  input  logic                        clk_i,
  input  logic                        arstN_i,
  input  logic                        push_i,
  input  logic [usbLitePkg::DATA_W-1:0] data_i,
  input  logic                        pop_i,
  output logic [usbLitePkg::DATA_W-1:0] data_o,
  output logic                        full_o,
  output logic                        empty_o
);
  import usbLitePkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wrPtr;
  logic [PTR_W-1:0]  rdPtr;
  logic [CNT_W-1:0]  count;
  logic              doPush;
  logic              doPop;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign doPush  = push_i && !full_o;
  assign doPop   = pop_i && !empty_o;
  assign data_o  = mem[rdPtr];  // Head is visible without a pop.

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (doPush) begin
      mem[wrPtr] <= data_i;
    end
  end

endmodule

// ==== design/usbLitePkg.sv ====
package usbLitePkg;

  // ####################################################################
  // Bus widths and register map.
  // ####################################################################
  localparam int ADDR_W = 8;
  localparam int DATA_W = 8;

  localparam logic [ADDR_W-1:0] ADDR_CONTROL  = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_STATUS   = 8'h01;
  localparam logic [ADDR_W-1:0] ADDR_INTMASK  = 8'h02;
  localparam logic [ADDR_W-1:0] ADDR_TXDATA   = 8'h03;
  localparam logic [ADDR_W-1:0] ADDR_RXDATA   = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_FIFOSTAT = 8'h05;

  // Control register bits.
  localparam int CTRL_W         = 3;
  localparam int CTRL_TXEN      = 0;
  localparam int CTRL_RXEN      = 1;
  localparam int CTRL_FULLSPEED = 2;

  // Status and mask share one layout.
  localparam int INT_W      = 3;
  localparam int INT_TXDONE = 0;
  localparam int INT_RXBYTE = 1;
  localparam int INT_RXOVF  = 2;

  localparam int FSTAT_W       = 3;
  localparam int FSTAT_TXFULL  = 0;
  localparam int FSTAT_TXEMPTY = 1;
  localparam int FSTAT_RXEMPTY = 2;

  // ####################################################################
  // FIFO sizes and line timing.
  // ####################################################################
  localparam int TX_FIFO_DEPTH = 16;
  localparam int RX_FIFO_DEPTH = 8;

  localparam int FS_DIV    = 4;   // Clocks per bit, full speed.
  localparam int LS_DIV    = 32;  // Clocks per bit, low speed.
  localparam int DIV_W     = $clog2(LS_DIV);
  localparam int BIT_CNT_W = $clog2(DATA_W);

endpackage
